/* hdl/lsq_pkg.sv */
package lsq_pkg;

    // address and queue sizing
    localparam int XLEN      = 32;
    localparam int LQ_DEPTH  = 16;
    localparam int LQ_IDX_W  = $clog2(LQ_DEPTH);
    // lq index plus its wrap bit
    localparam int LQ_PTR_W  = LQ_IDX_W + 1;
    // occupancy counter, 0 up to LQ_DEPTH
    localparam int CNT_W     = $clog2(LQ_DEPTH + 1);
    localparam int ENQ_WIDTH = 2;
    localparam int ENQ_CNT_W = $clog2(ENQ_WIDTH + 1);

    // rob and sq indices carry a wrap bit in the msb
    localparam int ROB_IDX_W = 7;
    localparam int SQ_IDX_W  = 5;
    localparam int MASK_W    = 8;

    // widest index part handled by the age compare
    localparam int AGE_IDX_W = ROB_IDX_W - 1;

    typedef enum logic [1:0] {
        LQ_FREE,
        LQ_ALLOC,
        LQ_ISSUED,
        LQ_DONE
    } lq_state_e;

    // number of active request bits
    function automatic logic [ENQ_CNT_W-1:0] count_ones(input logic [ENQ_WIDTH-1:0] req);
        logic [ENQ_CNT_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < ENQ_WIDTH; i++) begin
            sum = sum + ENQ_CNT_W'(req[i]);
        end
        return sum;
    endfunction

    // true when a is older than b
    // same wrap bit means plain compare, a differing wrap bit flips it
    function automatic logic is_older(input logic a_wrap, input logic [AGE_IDX_W-1:0] a_idx,
                                      input logic b_wrap, input logic [AGE_IDX_W-1:0] b_idx);
        logic older;
        if (a_wrap == b_wrap) begin
            older = a_idx < b_idx;
        end else begin
            older = a_idx > b_idx;
        end
        return older;
    endfunction

endpackage

/* hdl/load_queue.sv */
`timescale 1ns/10ps

module load_queue import lsq_pkg::*; (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    // dispatch
    input  logic [ENQ_WIDTH-1:0] i_enq_req,
    input  logic [ROB_IDX_W-1:0] i_enq_rob_idx [ENQ_WIDTH],
    input  logic [SQ_IDX_W-1:0]  i_enq_sq_idx [ENQ_WIDTH],
    output logic                 o_can_enq,
    output logic [LQ_PTR_W-1:0]  o_alloc_lq_idx [ENQ_WIDTH],
    // load pipe and writeback
    input  logic                 i_ld_vld,
    input  logic [LQ_PTR_W-1:0]  i_ld_lq_idx,
    input  logic [XLEN-1:0]      i_ld_vaddr,
    input  logic [MASK_W-1:0]    i_ld_mask,
    input  logic                 i_wb_vld,
    input  logic [LQ_PTR_W-1:0]  i_wb_lq_idx,
    // retirement
    input  logic                 i_commit,
    output logic                 o_head_done,
    output logic [ROB_IDX_W-1:0] o_head_rob_idx,
    // entry view for the violation check
    output lq_state_e            o_ent_state [LQ_DEPTH],
    output logic [ROB_IDX_W-1:0] o_ent_rob_idx [LQ_DEPTH],
    output logic [SQ_IDX_W-1:0]  o_ent_sq_idx [LQ_DEPTH],
    output logic [XLEN-1:0]      o_ent_vaddr [LQ_DEPTH],
    output logic [MASK_W-1:0]    o_ent_mask [LQ_DEPTH]
);

    lq_state_e            ent_state [LQ_DEPTH];
    logic [ROB_IDX_W-1:0] ent_rob_idx [LQ_DEPTH];
    logic [SQ_IDX_W-1:0]  ent_sq_idx [LQ_DEPTH];
    logic [XLEN-1:0]      ent_vaddr [LQ_DEPTH];
    logic [MASK_W-1:0]    ent_mask [LQ_DEPTH];

    logic [LQ_PTR_W-1:0]  tail_ptr;
    logic [LQ_PTR_W-1:0]  head_ptr;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     free_cnt;

    logic [ENQ_CNT_W-1:0] enq_num;
    logic [ENQ_CNT_W-1:0] real_enq_num;
    logic [ENQ_WIDTH-1:0] real_enq_vld;

    logic [LQ_IDX_W-1:0]  head_idx;
    logic [LQ_IDX_W-1:0]  ld_idx;
    logic [LQ_IDX_W-1:0]  wb_idx;

    assign head_idx = head_ptr[LQ_IDX_W-1:0];
    assign ld_idx   = i_ld_lq_idx[LQ_IDX_W-1:0];
    assign wb_idx   = i_wb_lq_idx[LQ_IDX_W-1:0];

    // enqueue only when every requested slot fits
    assign free_cnt     = CNT_W'(LQ_DEPTH) - count;
    assign enq_num      = count_ones(i_enq_req);
    assign o_can_enq    = CNT_W'(enq_num) <= free_cnt;
    assign real_enq_vld = o_can_enq ? i_enq_req : '0;
    assign real_enq_num = o_can_enq ? enq_num : '0;

    // requested slots take consecutive indices, wrap bit rides in the msb
    always_comb begin
        logic [LQ_PTR_W-1:0] ptr;
        ptr = tail_ptr;
        for (int s = 0; s < ENQ_WIDTH; s++) begin
            o_alloc_lq_idx[s] = ptr;
            if (i_enq_req[s]) begin
                ptr = ptr + 1'b1;
            end
        end
    end

    assign o_head_done    = ent_state[head_idx] == LQ_DONE;
    assign o_head_rob_idx = ent_rob_idx[head_idx];

    // pointers, count and entry states
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
            for (int e = 0; e < LQ_DEPTH; e++) begin
                ent_state[e] <= LQ_FREE;
            end
        end else if (i_flush) begin
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
            for (int e = 0; e < LQ_DEPTH; e++) begin
                ent_state[e] <= LQ_FREE;
            end
        end else begin
            tail_ptr <= tail_ptr + LQ_PTR_W'(real_enq_num);
            count    <= count + CNT_W'(real_enq_num) - CNT_W'(i_commit);

            if (i_commit) begin
                ent_state[head_idx] <= LQ_FREE;
                head_ptr            <= head_ptr + 1'b1;
            end
            if (i_wb_vld && ent_state[wb_idx] == LQ_ISSUED) begin
                ent_state[wb_idx] <= LQ_DONE;
            end
            if (i_ld_vld) begin
                ent_state[ld_idx] <= LQ_ISSUED;
            end
            for (int s = 0; s < ENQ_WIDTH; s++) begin
                if (real_enq_vld[s]) begin
                    ent_state[o_alloc_lq_idx[s][LQ_IDX_W-1:0]] <= LQ_ALLOC;
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        for (int s = 0; s < ENQ_WIDTH; s++) begin
            if (real_enq_vld[s]) begin
                ent_rob_idx[o_alloc_lq_idx[s][LQ_IDX_W-1:0]] <= i_enq_rob_idx[s];
                ent_sq_idx[o_alloc_lq_idx[s][LQ_IDX_W-1:0]]  <= i_enq_sq_idx[s];
            end
        end
        if (i_ld_vld) begin
            ent_vaddr[ld_idx] <= i_ld_vaddr;
            ent_mask[ld_idx]  <= i_ld_mask;
        end
    end

    assign o_ent_state   = ent_state;
    assign o_ent_rob_idx = ent_rob_idx;
    assign o_ent_sq_idx  = ent_sq_idx;
    assign o_ent_vaddr   = ent_vaddr;
    assign o_ent_mask    = ent_mask;

    // rob may only retire a finished head
    a_commit_head_done: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_commit |-> o_head_done
    );

    // load pipe targets a dispatched entry that has no address yet
    a_ld_to_alloc: assert property (
        @(posedge clk) disable iff (!i_rst_n || i_flush) i_ld_vld |-> ent_state[ld_idx] == LQ_ALLOC
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (!i_rst_n) count <= CNT_W'(LQ_DEPTH)
    );

endmodule

/* hdl/load_violation_check.sv */
`timescale 1ns/10ps

module load_violation_check import lsq_pkg::*; (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    // store address execute
    input  logic                 i_sta_vld,
    input  logic [SQ_IDX_W-1:0]  i_sta_sq_idx,
    input  logic [XLEN-1:0]      i_sta_vaddr,
    input  logic [MASK_W-1:0]    i_sta_mask,
    // entry view from the queue
    input  lq_state_e            i_ent_state [LQ_DEPTH],
    input  logic [ROB_IDX_W-1:0] i_ent_rob_idx [LQ_DEPTH],
    input  logic [SQ_IDX_W-1:0]  i_ent_sq_idx [LQ_DEPTH],
    input  logic [XLEN-1:0]      i_ent_vaddr [LQ_DEPTH],
    input  logic [MASK_W-1:0]    i_ent_mask [LQ_DEPTH],
    // rollback report
    output logic                 o_violation,
    output logic [ROB_IDX_W-1:0] o_violation_rob_idx
);

    logic [LQ_DEPTH-1:0]  viol_vec;
    logic                 viol_any;
    logic [ROB_IDX_W-1:0] oldest_rob;

    // per entry match against the store
    always_comb begin
        for (int j = 0; j < LQ_DEPTH; j++) begin
            viol_vec[j] = i_sta_vld &&
                (i_ent_state[j] == LQ_ISSUED || i_ent_state[j] == LQ_DONE) &&
                is_older(i_sta_sq_idx[SQ_IDX_W-1],
                         AGE_IDX_W'(i_sta_sq_idx[SQ_IDX_W-2:0]),
                         i_ent_sq_idx[j][SQ_IDX_W-1],
                         AGE_IDX_W'(i_ent_sq_idx[j][SQ_IDX_W-2:0])) &&
                (i_ent_vaddr[j][XLEN-1:3] == i_sta_vaddr[XLEN-1:3]) &&
                ((i_ent_mask[j] & i_sta_mask) != '0);
        end
    end

    // pick the oldest violating load by rob order
    always_comb begin
        viol_any   = 1'b0;
        oldest_rob = '0;
        for (int j = 0; j < LQ_DEPTH; j++) begin
            if (viol_vec[j]) begin
                if (!viol_any ||
                    is_older(i_ent_rob_idx[j][ROB_IDX_W-1],
                             i_ent_rob_idx[j][ROB_IDX_W-2:0],
                             oldest_rob[ROB_IDX_W-1],
                             oldest_rob[ROB_IDX_W-2:0])) begin
                    oldest_rob = i_ent_rob_idx[j];
                end
                viol_any = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_violation <= 1'b0;
        end else begin
            // flush drops a pending report
            o_violation <= viol_any && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (viol_any) begin
            o_violation_rob_idx <= oldest_rob;
        end
    end

    // a report always belongs to a store checked the cycle before
    a_viol_needs_sta: assert property (
        @(posedge clk) disable iff (!i_rst_n) !i_sta_vld |=> !o_violation
    );

endmodule

/* hdl/lsq_top.sv */
`timescale 1ns/10ps

module lsq_top import lsq_pkg::*; (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    // dispatch
    input  logic [ENQ_WIDTH-1:0] i_enq_req,
    input  logic [ROB_IDX_W-1:0] i_enq_rob_idx [ENQ_WIDTH],
    input  logic [SQ_IDX_W-1:0]  i_enq_sq_idx [ENQ_WIDTH],
    output logic                 o_can_enq,
    output logic [LQ_PTR_W-1:0]  o_alloc_lq_idx [ENQ_WIDTH],
    // load pipe and writeback
    input  logic                 i_ld_vld,
    input  logic [LQ_PTR_W-1:0]  i_ld_lq_idx,
    input  logic [XLEN-1:0]      i_ld_vaddr,
    input  logic [MASK_W-1:0]    i_ld_mask,
    input  logic                 i_wb_vld,
    input  logic [LQ_PTR_W-1:0]  i_wb_lq_idx,
    // retirement
    input  logic                 i_commit,
    output logic                 o_head_done,
    output logic [ROB_IDX_W-1:0] o_head_rob_idx,
    // store check
    input  logic                 i_sta_vld,
    input  logic [SQ_IDX_W-1:0]  i_sta_sq_idx,
    input  logic [XLEN-1:0]      i_sta_vaddr,
    input  logic [MASK_W-1:0]    i_sta_mask,
    output logic                 o_violation,
    output logic [ROB_IDX_W-1:0] o_violation_rob_idx
);

    lq_state_e            ent_state [LQ_DEPTH];
    logic [ROB_IDX_W-1:0] ent_rob_idx [LQ_DEPTH];
    logic [SQ_IDX_W-1:0]  ent_sq_idx [LQ_DEPTH];
    logic [XLEN-1:0]      ent_vaddr [LQ_DEPTH];
    logic [MASK_W-1:0]    ent_mask [LQ_DEPTH];

    load_queue u_load_queue (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .i_enq_req      (i_enq_req),
        .i_enq_rob_idx  (i_enq_rob_idx),
        .i_enq_sq_idx   (i_enq_sq_idx),
        .o_can_enq      (o_can_enq),
        .o_alloc_lq_idx (o_alloc_lq_idx),
        .i_ld_vld       (i_ld_vld),
        .i_ld_lq_idx    (i_ld_lq_idx),
        .i_ld_vaddr     (i_ld_vaddr),
        .i_ld_mask      (i_ld_mask),
        .i_wb_vld       (i_wb_vld),
        .i_wb_lq_idx    (i_wb_lq_idx),
        .i_commit       (i_commit),
        .o_head_done    (o_head_done),
        .o_head_rob_idx (o_head_rob_idx),
        .o_ent_state    (ent_state),
        .o_ent_rob_idx  (ent_rob_idx),
        .o_ent_sq_idx   (ent_sq_idx),
        .o_ent_vaddr    (ent_vaddr),
        .o_ent_mask     (ent_mask)
    );

    load_violation_check u_violation_check (
        .clk                 (clk),
        .i_rst_n             (i_rst_n),
        .i_flush             (i_flush),
        .i_sta_vld           (i_sta_vld),
        .i_sta_sq_idx        (i_sta_sq_idx),
        .i_sta_vaddr         (i_sta_vaddr),
        .i_sta_mask          (i_sta_mask),
        .i_ent_state         (ent_state),
        .i_ent_rob_idx       (ent_rob_idx),
        .i_ent_sq_idx        (ent_sq_idx),
        .i_ent_vaddr         (ent_vaddr),
        .i_ent_mask          (ent_mask),
        .o_violation         (o_violation),
        .o_violation_rob_idx (o_violation_rob_idx)
    );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    // 20 ns period
    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 8;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) o_clk = ~o_clk;
        end
    end

    // release reset on a falling edge, away from the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

/* tests/lsq_tb.sv */
`timescale 1ns/10ps

module lsq_tb import lsq_pkg::*; ();

    localparam logic [31:0] SEED = 32'h5624114a;
    localparam int TEST_CYCLES     = 1000;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic                 clk;
    logic                 rst_n;
    logic                 i_flush;
    logic [ENQ_WIDTH-1:0] i_enq_req;
    logic [ROB_IDX_W-1:0] i_enq_rob_idx [ENQ_WIDTH];
    logic [SQ_IDX_W-1:0]  i_enq_sq_idx [ENQ_WIDTH];
    logic                 o_can_enq;
    logic [LQ_PTR_W-1:0]  o_alloc_lq_idx [ENQ_WIDTH];
    logic                 i_ld_vld;
    logic [LQ_PTR_W-1:0]  i_ld_lq_idx;
    logic [XLEN-1:0]      i_ld_vaddr;
    logic [MASK_W-1:0]    i_ld_mask;
    logic                 i_wb_vld;
    logic [LQ_PTR_W-1:0]  i_wb_lq_idx;
    logic                 i_commit;
    logic                 o_head_done;
    logic [ROB_IDX_W-1:0] o_head_rob_idx;
    logic                 i_sta_vld;
    logic [SQ_IDX_W-1:0]  i_sta_sq_idx;
    logic [XLEN-1:0]      i_sta_vaddr;
    logic [MASK_W-1:0]    i_sta_mask;
    logic                 o_violation;
    logic [ROB_IDX_W-1:0] o_violation_rob_idx;

    // reference model of the entries
    lq_state_e            m_state [LQ_DEPTH];
    logic [ROB_IDX_W-1:0] m_rob [LQ_DEPTH];
    logic [SQ_IDX_W-1:0]  m_sq [LQ_DEPTH];
    logic [XLEN-1:0]      m_addr [LQ_DEPTH];
    logic [MASK_W-1:0]    m_mask [LQ_DEPTH];
    logic [LQ_PTR_W-1:0]  m_head;
    logic [LQ_PTR_W-1:0]  m_tail;

    logic                 exp_can_enq;
    logic [LQ_PTR_W-1:0]  exp_alloc [ENQ_WIDTH];
    logic                 exp_head_done;
    logic [ROB_IDX_W-1:0] exp_head_rob;
    logic                 exp_viol;
    logic [ROB_IDX_W-1:0] exp_viol_rob;
    logic                 exp_viol_q;
    logic [ROB_IDX_W-1:0] exp_viol_rob_q;

    logic [31:0]          rng_state;
    logic [ROB_IDX_W-1:0] rob_next;
    logic [SQ_IDX_W-1:0]  sq_next;

    tb_clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    lsq_top u_dut (
        .clk                 (clk),
        .i_rst_n             (rst_n),
        .i_flush             (i_flush),
        .i_enq_req           (i_enq_req),
        .i_enq_rob_idx       (i_enq_rob_idx),
        .i_enq_sq_idx        (i_enq_sq_idx),
        .o_can_enq           (o_can_enq),
        .o_alloc_lq_idx      (o_alloc_lq_idx),
        .i_ld_vld            (i_ld_vld),
        .i_ld_lq_idx         (i_ld_lq_idx),
        .i_ld_vaddr          (i_ld_vaddr),
        .i_ld_mask           (i_ld_mask),
        .i_wb_vld            (i_wb_vld),
        .i_wb_lq_idx         (i_wb_lq_idx),
        .i_commit            (i_commit),
        .o_head_done         (o_head_done),
        .o_head_rob_idx      (o_head_rob_idx),
        .i_sta_vld           (i_sta_vld),
        .i_sta_sq_idx        (i_sta_sq_idx),
        .i_sta_vaddr         (i_sta_vaddr),
        .i_sta_mask          (i_sta_mask),
        .o_violation         (o_violation),
        .o_violation_rob_idx (o_violation_rob_idx)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // a is older when the modular distance a - b is negative
    function automatic logic sq_is_before(input logic [SQ_IDX_W-1:0] a,
                                          input logic [SQ_IDX_W-1:0] b);
        logic [SQ_IDX_W-1:0] diff;
        diff = a - b;
        return diff[SQ_IDX_W-1];
    endfunction

    function automatic logic rob_is_before(input logic [ROB_IDX_W-1:0] a,
                                           input logic [ROB_IDX_W-1:0] b);
        logic [ROB_IDX_W-1:0] diff;
        diff = a - b;
        return diff[ROB_IDX_W-1];
    endfunction

    // expected outputs from the model state and the current inputs
    always_comb begin
        logic [LQ_PTR_W-1:0] occupied;
        logic [LQ_PTR_W-1:0] ptr;
        int                  n_req;
        occupied = m_tail - m_head;
        n_req    = 0;
        ptr      = m_tail;
        for (int s = 0; s < ENQ_WIDTH; s++) begin
            n_req        = n_req + int'(i_enq_req[s]);
            exp_alloc[s] = ptr;
            ptr          = ptr + LQ_PTR_W'(i_enq_req[s]);
        end
        exp_can_enq   = n_req <= LQ_DEPTH - int'(occupied);
        exp_head_done = m_state[m_head[LQ_IDX_W-1:0]] == LQ_DONE;
        exp_head_rob  = m_rob[m_head[LQ_IDX_W-1:0]];
        exp_viol      = 1'b0;
        exp_viol_rob  = '0;
        for (int j = 0; j < LQ_DEPTH; j++) begin
            if (i_sta_vld && (m_state[j] == LQ_ISSUED || m_state[j] == LQ_DONE) &&
                sq_is_before(i_sta_sq_idx, m_sq[j]) &&
                m_addr[j][XLEN-1:3] == i_sta_vaddr[XLEN-1:3] &&
                (m_mask[j] & i_sta_mask) != '0) begin
                if (!exp_viol || rob_is_before(m_rob[j], exp_viol_rob)) begin
                    exp_viol_rob = m_rob[j];
                end
                exp_viol = 1'b1;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        logic [LQ_PTR_W-1:0] t;
        if (!rst_n || i_flush) begin
            m_head <= '0;
            m_tail <= '0;
            for (int e = 0; e < LQ_DEPTH; e++) begin
                m_state[e] <= LQ_FREE;
            end
        end else begin
            t = m_tail;
            for (int s = 0; s < ENQ_WIDTH; s++) begin
                if (exp_can_enq && i_enq_req[s]) begin
                    m_state[t[LQ_IDX_W-1:0]] <= LQ_ALLOC;
                    m_rob[t[LQ_IDX_W-1:0]]   <= i_enq_rob_idx[s];
                    m_sq[t[LQ_IDX_W-1:0]]    <= i_enq_sq_idx[s];
                    t = t + 1'b1;
                end
            end
            m_tail <= t;
            if (i_ld_vld) begin
                m_state[i_ld_lq_idx[LQ_IDX_W-1:0]] <= LQ_ISSUED;
                m_addr[i_ld_lq_idx[LQ_IDX_W-1:0]]  <= i_ld_vaddr;
                m_mask[i_ld_lq_idx[LQ_IDX_W-1:0]]  <= i_ld_mask;
            end
            if (i_wb_vld && m_state[i_wb_lq_idx[LQ_IDX_W-1:0]] == LQ_ISSUED) begin
                m_state[i_wb_lq_idx[LQ_IDX_W-1:0]] <= LQ_DONE;
            end
            if (i_commit) begin
                m_state[m_head[LQ_IDX_W-1:0]] <= LQ_FREE;
                m_head <= m_head + 1'b1;
            end
        end
    end

    // violation report lands one cycle after the store check
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_viol_q <= 1'b0;
        end else begin
            exp_viol_q <= exp_viol && !i_flush;
            if (exp_viol) begin
                exp_viol_rob_q <= exp_viol_rob;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("FAILED %s: expected 0x%h, got 0x%h", name, exp_val, act_val);
        $display("Test failures found");
        $fatal(1, "output mismatch");
    endtask

    a_can_enq: assert property (@(posedge clk) disable iff (!rst_n)
        o_can_enq == exp_can_enq)
        else report_mismatch("o_can_enq", 32'($sampled(exp_can_enq)), 32'($sampled(o_can_enq)));
    a_alloc_slot0: assert property (@(posedge clk) disable iff (!rst_n)
        i_enq_req[0] |-> o_alloc_lq_idx[0] == exp_alloc[0])
        else report_mismatch("o_alloc_lq_idx[0]", 32'($sampled(exp_alloc[0])),
                             32'($sampled(o_alloc_lq_idx[0])));
    a_alloc_slot1: assert property (@(posedge clk) disable iff (!rst_n)
        i_enq_req[1] |-> o_alloc_lq_idx[1] == exp_alloc[1])
        else report_mismatch("o_alloc_lq_idx[1]", 32'($sampled(exp_alloc[1])),
                             32'($sampled(o_alloc_lq_idx[1])));
    a_head_done: assert property (@(posedge clk) disable iff (!rst_n)
        o_head_done == exp_head_done)
        else report_mismatch("o_head_done", 32'($sampled(exp_head_done)),
                             32'($sampled(o_head_done)));
    a_head_rob: assert property (@(posedge clk) disable iff (!rst_n)
        exp_head_done |-> o_head_rob_idx == exp_head_rob)
        else report_mismatch("o_head_rob_idx", 32'($sampled(exp_head_rob)),
                             32'($sampled(o_head_rob_idx)));
    a_violation: assert property (@(posedge clk) disable iff (!rst_n)
        o_violation == exp_viol_q)
        else report_mismatch("o_violation", 32'($sampled(exp_viol_q)),
                             32'($sampled(o_violation)));
    a_viol_rob: assert property (@(posedge clk) disable iff (!rst_n)
        exp_viol_q |-> o_violation_rob_idx == exp_viol_rob_q)
        else report_mismatch("o_violation_rob_idx", 32'($sampled(exp_viol_rob_q)),
                             32'($sampled(o_violation_rob_idx)));

    task automatic drive_idle();
        i_flush   = 1'b0;
        i_enq_req = '0;
        for (int s = 0; s < ENQ_WIDTH; s++) begin
            i_enq_rob_idx[s] = '0;
            i_enq_sq_idx[s]  = '0;
        end
        i_ld_vld     = 1'b0;
        i_ld_lq_idx  = '0;
        i_ld_vaddr   = '0;
        i_ld_mask    = '0;
        i_wb_vld     = 1'b0;
        i_wb_lq_idx  = '0;
        i_commit     = 1'b0;
        i_sta_vld    = 1'b0;
        i_sta_sq_idx = '0;
        i_sta_vaddr  = '0;
        i_sta_mask   = '0;
    endtask

    // rob indices grow in program order with one store between loads
    task automatic enqueue(input logic [ENQ_WIDTH-1:0] req);
        i_enq_req = req;
        for (int s = 0; s < ENQ_WIDTH; s++) begin
            i_enq_rob_idx[s] = rob_next;
            i_enq_sq_idx[s]  = sq_next;
            rob_next = rob_next + ROB_IDX_W'(1 + (next_rand() & 32'd1));
            sq_next  = sq_next + 1'b1;
        end
        @(negedge clk);
        i_enq_req = '0;
    endtask

    task automatic issue_load(input logic [LQ_PTR_W-1:0] ptr, input logic [XLEN-1:0] addr,
                              input logic [MASK_W-1:0] mask);
        i_ld_vld    = 1'b1;
        i_ld_lq_idx = ptr;
        i_ld_vaddr  = addr;
        i_ld_mask   = mask;
        @(negedge clk);
        i_ld_vld = 1'b0;
    endtask

    task automatic writeback(input logic [LQ_PTR_W-1:0] ptr);
        i_wb_vld    = 1'b1;
        i_wb_lq_idx = ptr;
        @(negedge clk);
        i_wb_vld = 1'b0;
    endtask

    // every finished load reads at least one byte
    task automatic finish_load(input logic [LQ_PTR_W-1:0] ptr);
        issue_load(ptr, next_rand(), MASK_W'(next_rand()) | 8'h01);
        writeback(ptr);
    endtask

    task automatic commit_head();
        i_commit = 1'b1;
        @(negedge clk);
        i_commit = 1'b0;
    endtask

    task automatic check_store(input logic [SQ_IDX_W-1:0] sq, input logic [XLEN-1:0] addr,
                               input logic [MASK_W-1:0] mask);
        i_sta_vld    = 1'b1;
        i_sta_sq_idx = sq;
        i_sta_vaddr  = addr;
        i_sta_mask   = mask;
        @(negedge clk);
        i_sta_vld = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: stimulus still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [LQ_PTR_W-1:0] ptr_a;
        logic [SQ_IDX_W-1:0] sq_a;
        logic [SQ_IDX_W-1:0] sq_b;
        logic [SQ_IDX_W-1:0] sq_c;
        logic [XLEN-1:0]     base;
        logic [XLEN-1:0]     base2;
        drive_idle();
        rng_state = SEED;
        rob_next  = ROB_IDX_W'(next_rand());
        sq_next   = SQ_IDX_W'(next_rand());
        @(posedge rst_n);
        @(negedge clk);

        // fill the queue with a refused pair at one free entry and a refused single when full
        repeat (7) enqueue(2'b11);
        enqueue(2'b01);
        enqueue(2'b11);
        enqueue(2'b10);
        enqueue(2'b01);

        // a finished entry behind the head keeps head_done low
        finish_load(5'd3);
        for (int k = 0; k < 3; k++) begin
            finish_load(LQ_PTR_W'(k));
        end
        repeat (4) commit_head();
        // these allocations cross the wrap
        enqueue(2'b11);
        enqueue(2'b11);
        for (int k = 4; k < 20; k++) begin
            finish_load(LQ_PTR_W'(k));
        end
        repeat (16) commit_head();

        // store checks against four fresh loads that issue one by one
        ptr_a = m_tail;
        enqueue(2'b11);
        enqueue(2'b11);
        sq_a  = m_sq[ptr_a[LQ_IDX_W-1:0]];
        sq_b  = m_sq[ptr_a[LQ_IDX_W-1:0] + 1'b1];
        sq_c  = m_sq[ptr_a[LQ_IDX_W-1:0] + 2'd2];
        base  = next_rand() & ~32'h7;
        // the third entry still holds the address and mask of an older load
        base2 = m_addr[ptr_a[LQ_IDX_W-1:0] + 2'd2] & ~32'h7;
        issue_load(ptr_a, base | 32'h1, 8'h0f);
        issue_load(ptr_a + 1'b1, base | 32'h4, 8'h30);
        writeback(ptr_a);
        check_store(sq_a - 1'b1, base, 8'hff);
        check_store(sq_a - 2'd2, base, 8'h20);
        check_store(sq_b, base, 8'hff);
        check_store(sq_a - 1'b1, base, 8'hc0);
        check_store(sq_a - 1'b1, base + 32'd8, 8'hff);
        check_store(sq_c - 1'b1, base2, 8'hff);
        issue_load(ptr_a + 2'd2, base2, 8'h01);
        check_store(sq_c - 1'b1, base2 | 32'h3, 8'h03);
        repeat (2) @(negedge clk);

        // a full pair after the flush restarts at index 0
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        enqueue(2'b11);
        repeat (3) @(negedge clk);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* lsq_top.f */
hdl/lsq_pkg.sv
hdl/load_queue.sv
hdl/load_violation_check.sv
hdl/lsq_top.sv
tests/tb_clock_gen.sv
tests/lsq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the load queue testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsq_tb \
    -f lsq_top.f --Mdir obj_dir -o lsq_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/lsq_sim > sim.log 2>&1
grep -q 'Test failures found' sim.log && { echo "simulation FAILED, see sim.log"; exit 1; } \
    || { grep -q 'All tests passed!' sim.log && echo "simulation passed"; } \
    || { echo "simulation ended without a result, see sim.log"; exit 1; }
